/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -Wno-fatal --top-module tb_internal_bus \
		-f flist.f --Mdir obj_dir -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* axil_master.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module axil_master import core_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req,
  input  logic                     req_write,
  input  logic [`CORE_ADDR_W-1:0]  req_addr,
  input  logic [`CORE_DATA_W-1:0]  req_wdata,
  output logic                     done,
  output logic [`CORE_DATA_W-1:0]  rd_data,
  output axi_resp_t                resp,
  output logic [`CORE_ADDR_W-1:0]  awaddr,
  output logic                     awvalid,
  input  logic                     awready,
  output logic [`CORE_DATA_W-1:0]  wdata,
  output logic [`CORE_DATA_W/8-1:0] wstrb,
  output logic                     wvalid,
  input  logic                     wready,
  input  axi_resp_t                bresp,
  input  logic                     bvalid,
  output logic                     bready,
  output logic [`CORE_ADDR_W-1:0]  araddr,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic [`CORE_DATA_W-1:0]  rdata,
  input  axi_resp_t                rresp,
  input  logic                     rvalid,
  output logic                     rready
);

  typedef enum logic [1:0] {
    M_IDLE  = 2'd0,
    M_READ  = 2'd1,
    M_WRITE = 2'd2
  } mst_state_t;

  mst_state_t state;

  // address and data channel still waiting after this edge
  logic aw_left;
  logic w_left;

  assign aw_left = awvalid && !awready;
  assign w_left  = wvalid && !wready;

  // full word writes only
  assign wstrb = '1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= M_IDLE;
      done    <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        M_IDLE: begin
          if (req && req_write) begin
            awaddr  <= req_addr;
            wdata   <= req_wdata;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            state   <= M_WRITE;
          end else if (req) begin
            araddr  <= req_addr;
            arvalid <= 1'b1;
            rready  <= 1'b1;
            state   <= M_READ;
          end
        end
        M_READ: begin
          if (arvalid && arready) begin
            arvalid <= 1'b0;
          end
          if (rready && rvalid) begin
            rready  <= 1'b0;
            rd_data <= rdata;
            resp    <= rresp;
            done    <= 1'b1;
            state   <= M_IDLE;
          end
        end
        M_WRITE: begin
          // aw and w complete independently
          if (awvalid && awready) begin
            awvalid <= 1'b0;
          end
          if (wvalid && wready) begin
            wvalid <= 1'b0;
          end
          if (!bready && !aw_left && !w_left) begin
            bready <= 1'b1;
          end
          if (bready && bvalid) begin
            bready <= 1'b0;
            resp   <= bresp;
            done   <= 1'b1;
            state  <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

/* cond_eval.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module cond_eval import core_pkg::*; (
  input  cond_t                   cond,
  input  logic [`CORE_DATA_W-1:0] src1,
  output logic                    taken
);

  logic is_zero;
  logic is_neg;

  assign is_zero = (src1 == '0);
  // sign bit of the operand
  assign is_neg  = src1[`CORE_DATA_W-1];

  always_comb begin
    case (cond)
      CND_ALWAYS: begin
        taken = 1'b1;
      end
      CND_ZERO: begin
        taken = is_zero;
      end
      CND_NONZERO: begin
        taken = !is_zero;
      end
      CND_NEG: begin
        taken = is_neg;
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  end

endmodule

/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// bus and datapath widths
`define CORE_ADDR_W 32
`define CORE_DATA_W 32
`define CORE_OFF_W  8

// command word layout
`define CMD_OP_HI   31
`define CMD_OP_LO   28
`define CMD_CND_HI  25
`define CMD_CND_LO  24
`define CMD_S1_HI   23
`define CMD_S1_LO   16
`define CMD_S0_HI   15
`define CMD_S0_LO   8
`define CMD_DST_HI  7
`define CMD_DST_LO  0

// bits 27..26 of the command are unused

`endif

/* core_pkg.sv */
package core_pkg;

  // command opcodes, codes above OP_HALT also stop the core
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_MOV  = 4'd7,
    OP_JMP  = 4'd8,
    OP_HALT = 4'd9
  } opcode_t;

  // condition codes, all tested on src1
  typedef enum logic [1:0] {
    CND_ALWAYS  = 2'd0,
    CND_ZERO    = 2'd1,
    CND_NONZERO = 2'd2,
    CND_NEG     = 2'd3
  } cond_t;

  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_FETCH   = 3'd1,
    ST_READ_S1 = 3'd2,
    ST_READ_S0 = 3'd3,
    ST_EXEC    = 3'd4,
    ST_WRITE   = 3'd5,
    ST_HALTED  = 3'd6
  } seq_state_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

/* exec_alu.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module exec_alu import core_pkg::*; (
  input  opcode_t                 op,
  input  logic [`CORE_DATA_W-1:0] src1,
  input  logic [`CORE_DATA_W-1:0] src0,
  output logic [`CORE_DATA_W-1:0] result
);

  // shift distance from the low bits of src0
  logic [4:0] shamt;

  assign shamt = src0[4:0];

  always_comb begin
    case (op)
      OP_ADD: begin
        result = src1 + src0;
      end
      OP_SUB: begin
        result = src1 - src0;
      end
      OP_AND: begin
        result = src1 & src0;
      end
      OP_OR: begin
        result = src1 | src0;
      end
      OP_XOR: begin
        result = src1 ^ src0;
      end
      OP_SHL: begin
        result = src1 << shamt;
      end
      OP_SHR: begin
        // logical shift, zero fill
        result = src1 >> shamt;
      end
      OP_MOV: begin
        result = src1;
      end
      default: begin
        // jmp, halt and unused codes write nothing
        result = '0;
      end
    endcase
  end

endmodule

/* flist.f */
+incdir+.
core_pkg.sv
axil_master.sv
exec_alu.sv
cond_eval.sv
step_sequencer.sv
internal_bus.sv
tb_checker.sv
tb_internal_bus.sv

/* internal_bus.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module internal_bus import core_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [`CORE_ADDR_W-1:0]   base_addr,
  input  logic [`CORE_ADDR_W-1:0]   base_addr_data,
  output logic [`CORE_ADDR_W-1:0]   awaddr,
  output logic                      awvalid,
  input  logic                      awready,
  output logic [`CORE_DATA_W-1:0]   wdata,
  output logic [`CORE_DATA_W/8-1:0] wstrb,
  output logic                      wvalid,
  input  logic                      wready,
  input  axi_resp_t                 bresp,
  input  logic                      bvalid,
  output logic                      bready,
  output logic [`CORE_ADDR_W-1:0]   araddr,
  output logic                      arvalid,
  input  logic                      arready,
  input  logic [`CORE_DATA_W-1:0]   rdata,
  input  axi_resp_t                 rresp,
  input  logic                      rvalid,
  output logic                      rready,
  output logic                      halted,
  output logic                      bus_error,
  output logic [`CORE_OFF_W-1:0]    ip
);

  // sequencer to bus master
  logic                    req;
  logic                    req_write;
  logic [`CORE_ADDR_W-1:0] req_addr;
  logic [`CORE_DATA_W-1:0] req_wdata;
  logic                    done;
  logic [`CORE_DATA_W-1:0] rd_data;
  axi_resp_t               resp;

  // latched command and operands to alu and condition
  opcode_t                 op;
  cond_t                   cond;
  logic [`CORE_DATA_W-1:0] src1;
  logic [`CORE_DATA_W-1:0] src0;
  logic [`CORE_DATA_W-1:0] result;
  logic                    taken;

  step_sequencer seq_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data),
    .done           (done),
    .rd_data        (rd_data),
    .resp           (resp),
    .result         (result),
    .taken          (taken),
    .req            (req),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .op             (op),
    .cond           (cond),
    .src1           (src1),
    .src0           (src0),
    .ip             (ip),
    .halted         (halted),
    .bus_error      (bus_error)
  );

  axil_master mst_i (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .done      (done),
    .rd_data   (rd_data),
    .resp      (resp),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready)
  );

  exec_alu alu_i (
    .op     (op),
    .src1   (src1),
    .src0   (src0),
    .result (result)
  );

  cond_eval cnd_i (
    .cond  (cond),
    .src1  (src1),
    .taken (taken)
  );

endmodule

/* step_sequencer.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module step_sequencer import core_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic [`CORE_ADDR_W-1:0] base_addr,
  input  logic [`CORE_ADDR_W-1:0] base_addr_data,
  input  logic                    done,
  input  logic [`CORE_DATA_W-1:0] rd_data,
  input  axi_resp_t               resp,
  input  logic [`CORE_DATA_W-1:0] result,
  input  logic                    taken,
  output logic                    req,
  output logic                    req_write,
  output logic [`CORE_ADDR_W-1:0] req_addr,
  output logic [`CORE_DATA_W-1:0] req_wdata,
  output opcode_t                 op,
  output cond_t                   cond,
  output logic [`CORE_DATA_W-1:0] src1,
  output logic [`CORE_DATA_W-1:0] src0,
  output logic [`CORE_OFF_W-1:0]  ip,
  output logic                    halted,
  output logic                    bus_error
);

  seq_state_t state;

  // high between a req pulse and its done
  logic                   wait_done;
  logic                   bus_fail;
  logic [`CORE_OFF_W-1:0] src1_off;
  logic [`CORE_OFF_W-1:0] src0_off;
  logic [`CORE_OFF_W-1:0] dst_off;

  // byte address of word number off above base
  function automatic logic [`CORE_ADDR_W-1:0] word_addr(
    input logic [`CORE_ADDR_W-1:0] base,
    input logic [`CORE_OFF_W-1:0]  off
  );
    return base + (`CORE_ADDR_W'(off) << 2);
  endfunction

  assign bus_fail = wait_done && done && (resp != RESP_OKAY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_IDLE;
      wait_done <= 1'b0;
      req       <= 1'b0;
      ip        <= '0;
      halted    <= 1'b0;
      bus_error <= 1'b0;
    end else begin
      req <= 1'b0;
      if (bus_fail) begin
        // any non-okay response stops the program
        wait_done <= 1'b0;
        bus_error <= 1'b1;
        halted    <= 1'b1;
        state     <= ST_HALTED;
      end else begin
        case (state)
          ST_IDLE, ST_HALTED: begin
            if (start) begin
              ip        <= '0;
              bus_error <= 1'b0;
              halted    <= 1'b0;
              state     <= ST_FETCH;
            end
          end
          ST_FETCH: begin
            if (!wait_done) begin
              req       <= 1'b1;
              req_write <= 1'b0;
              req_addr  <= word_addr(base_addr, ip);
              wait_done <= 1'b1;
            end else if (done) begin
              wait_done <= 1'b0;
              // halt and unknown codes stop here, ip stays on the command
              if (rd_data[`CMD_OP_HI:`CMD_OP_LO] >= OP_HALT) begin
                halted <= 1'b1;
                state  <= ST_HALTED;
              end else begin
                op       <= opcode_t'(rd_data[`CMD_OP_HI:`CMD_OP_LO]);
                cond     <= cond_t'(rd_data[`CMD_CND_HI:`CMD_CND_LO]);
                src1_off <= rd_data[`CMD_S1_HI:`CMD_S1_LO];
                src0_off <= rd_data[`CMD_S0_HI:`CMD_S0_LO];
                dst_off  <= rd_data[`CMD_DST_HI:`CMD_DST_LO];
                state    <= ST_READ_S1;
              end
            end
          end
          ST_READ_S1: begin
            if (!wait_done) begin
              req       <= 1'b1;
              req_write <= 1'b0;
              req_addr  <= word_addr(base_addr_data, src1_off);
              wait_done <= 1'b1;
            end else if (done) begin
              wait_done <= 1'b0;
              src1      <= rd_data;
              state     <= ST_READ_S0;
            end
          end
          ST_READ_S0: begin
            if (!wait_done) begin
              req       <= 1'b1;
              req_write <= 1'b0;
              req_addr  <= word_addr(base_addr_data, src0_off);
              wait_done <= 1'b1;
            end else if (done) begin
              wait_done <= 1'b0;
              src0      <= rd_data;
              state     <= ST_EXEC;
            end
          end
          ST_EXEC: begin
            // alu and condition settle on the latched operands
            if (op == OP_JMP) begin
              if (taken) begin
                ip <= dst_off;
              end else begin
                ip <= ip + 1'b1;
              end
              state <= ST_FETCH;
            end else if (taken) begin
              req_wdata <= result;
              state     <= ST_WRITE;
            end else begin
              ip    <= ip + 1'b1;
              state <= ST_FETCH;
            end
          end
          ST_WRITE: begin
            if (!wait_done) begin
              req       <= 1'b1;
              req_write <= 1'b1;
              req_addr  <= word_addr(base_addr_data, dst_off);
              wait_done <= 1'b1;
            end else if (done) begin
              wait_done <= 1'b0;
              ip        <= ip + 1'b1;
              state     <= ST_FETCH;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module tb_checker import core_pkg::*; (
  input logic                      clk,
  input logic [`CORE_ADDR_W-1:0]   awaddr,
  input logic                      awvalid,
  input logic                      awready,
  input logic [`CORE_DATA_W-1:0]   wdata,
  input logic [`CORE_DATA_W/8-1:0] wstrb,
  input logic                      wvalid,
  input logic                      wready,
  input logic                      halted,
  input logic                      bus_error,
  input logic [`CORE_OFF_W-1:0]    ip
);

  // copy of the memory image, words 256 and up hold data
  logic [`CORE_DATA_W-1:0] ref_mem [0:511];
  logic [`CORE_ADDR_W-1:0] exp_addr_q [$];
  logic [`CORE_DATA_W-1:0] exp_data_q [$];
  logic [`CORE_ADDR_W-1:0] ref_base;
  logic [`CORE_ADDR_W-1:0] ref_dbase;
  logic [`CORE_ADDR_W-1:0] ref_err_addr;
  logic                    ref_err_en = 1'b0;
  logic [`CORE_OFF_W-1:0]  exp_ip;
  logic                    exp_err;
  logic [`CORE_ADDR_W-1:0] seen_addr;
  logic [`CORE_DATA_W-1:0] seen_data;
  logic                    aw_got = 1'b0;
  logic                    w_got = 1'b0;
  logic                    halted_d = 1'b0;
  logic [`CORE_ADDR_W-1:0] e_addr;
  logic [`CORE_DATA_W-1:0] e_data;
  int                      test_id = 0;
  int                      test_errs = 0;
  int                      write_idx = 0;
  int                      pass_count = 0;
  int                      fail_count = 0;

  function automatic logic faults(input logic [`CORE_ADDR_W-1:0] addr);
    return ref_err_en && (addr == ref_err_addr);
  endfunction

  function automatic logic [31:0] alu_ref(input logic [3:0] opc, input logic [31:0] a,
                                          input logic [31:0] b);
    case (opc)
      OP_ADD: return a + b;
      OP_SUB: return a - b;
      OP_AND: return a & b;
      OP_OR:  return a | b;
      OP_XOR: return a ^ b;
      OP_SHL: return a << b[4:0];
      OP_SHR: return a >> b[4:0];
      OP_MOV: return a;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic cond_ref(input logic [1:0] cnd, input logic [31:0] a);
    case (cnd)
      CND_ZERO:    return a == 32'd0;
      CND_NONZERO: return a != 32'd0;
      CND_NEG:     return a[31];
      default:     return 1'b1;
    endcase
  endfunction

  // runs the program on the copy, fills the expected writes, returns commands executed
  function automatic int interpret();
    logic [`CORE_OFF_W-1:0] rip;
    logic [31:0]            cmd;
    logic [31:0]            faddr;
    logic [31:0]            a_addr;
    logic [31:0]            b_addr;
    logic [31:0]            d_addr;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            res;
    logic                   stop;
    int                     steps;
    rip = '0;
    stop = 1'b0;
    steps = 0;
    exp_err = 1'b0;
    while (!stop && steps < 1000) begin
      steps++;
      faddr = ref_base + {22'd0, rip, 2'b00};
      cmd = ref_mem[faddr[10:2]];
      a_addr = ref_dbase + {22'd0, cmd[23:16], 2'b00};
      b_addr = ref_dbase + {22'd0, cmd[15:8], 2'b00};
      d_addr = ref_dbase + {22'd0, cmd[7:0], 2'b00};
      a = ref_mem[a_addr[10:2]];
      b = ref_mem[b_addr[10:2]];
      if (faults(faddr) || (cmd[31:28] <= 4'd8 && (faults(a_addr) || faults(b_addr)))) begin
        stop = 1'b1;
        exp_err = 1'b1;
      end else if (cmd[31:28] > 4'd8) begin
        // halt or unused code, ip stays put
        stop = 1'b1;
      end else if (cmd[31:28] == OP_JMP) begin
        rip = cond_ref(cmd[25:24], a) ? cmd[7:0] : rip + 8'd1;
      end else if (!cond_ref(cmd[25:24], a)) begin
        rip = rip + 8'd1;
      end else begin
        res = alu_ref(cmd[31:28], a, b);
        exp_addr_q.push_back(d_addr);
        exp_data_q.push_back(res);
        if (faults(d_addr)) begin
          stop = 1'b1;
          exp_err = 1'b1;
        end else begin
          ref_mem[d_addr[10:2]] = res;
          rip = rip + 8'd1;
        end
      end
    end
    exp_ip = rip;
    return steps;
  endfunction

  task automatic load_word(input logic [8:0] idx, input logic [31:0] val);
    ref_mem[idx] = val;
  endtask

  task automatic begin_test(input int id, input logic [31:0] base, input logic [31:0] dbase,
                            input logic err_en, input logic [31:0] err_addr, output int cmds);
    test_id = id;
    test_errs = 0;
    write_idx = 0;
    ref_base = base;
    ref_dbase = dbase;
    ref_err_en = err_en;
    ref_err_addr = err_addr;
    exp_addr_q.delete();
    exp_data_q.delete();
    cmds = interpret();
  endtask

  task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
    if (exp_addr_q.size() == 0) begin
      $display("[ERROR] t=%0t: test %0d wrote %h to %h, no write expected",
               $time, test_id, data, addr);
      test_errs++;
    end else begin
      e_addr = exp_addr_q.pop_front();
      e_data = exp_data_q.pop_front();
      if (addr != e_addr || data != e_data) begin
        $display("[ERROR] t=%0t: test %0d write %0d got %h at %h, expected %h at %h",
                 $time, test_id, write_idx, data, addr, e_data, e_addr);
        test_errs++;
      end
      write_idx++;
    end
  endtask

  task automatic finish_test();
    if (exp_addr_q.size() != 0) begin
      $display("test %0d: %0d expected writes never happened", test_id, exp_addr_q.size());
      test_errs++;
    end
    if (ip != exp_ip || bus_error != exp_err) begin
      $display("[ERROR] t=%0t: test %0d ended with ip %0d bus_error %0b, expected %0d %0b",
               $time, test_id, ip, bus_error, exp_ip, exp_err);
      test_errs++;
    end
    if (test_errs == 0) begin
      pass_count++;
      $display("test %0d ok: %0d writes, ip %0d, bus_error %0b", test_id, write_idx, ip, bus_error);
    end else begin
      fail_count++;
      $display("test %0d bad: %0d errors", test_id, test_errs);
    end
  endtask

  // aw and w may complete in different cycles
  always @(posedge clk) begin
    if (awvalid && awready) begin
      aw_got = 1'b1;
      seen_addr = awaddr;
    end
    if (wvalid && wready) begin
      w_got = 1'b1;
      seen_data = wdata;
      if (wstrb != 4'hf) begin
        $display("[ERROR] t=%0t: test %0d wstrb %h is not all ones", $time, test_id, wstrb);
        test_errs++;
      end
    end
    if (aw_got && w_got) begin
      aw_got = 1'b0;
      w_got = 1'b0;
      check_write(seen_addr, seen_data);
    end
    if (halted && !halted_d) begin
      finish_test();
    end
    halted_d = halted;
  end

endmodule

/* tb_internal_bus.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module tb_internal_bus import core_pkg::*; ();

  localparam logic [31:0] PROG_BASE = 32'h0000_0000;
  // data words start at memory word 256
  localparam logic [31:0] DATA_BASE = 32'h0000_0400;

  logic                      clk;
  logic                      rst;
  logic                      start;
  logic [`CORE_ADDR_W-1:0]   base_addr;
  logic [`CORE_ADDR_W-1:0]   base_addr_data;
  logic [`CORE_ADDR_W-1:0]   awaddr;
  logic                      awvalid;
  logic                      awready;
  logic [`CORE_DATA_W-1:0]   wdata;
  logic [`CORE_DATA_W/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  axi_resp_t                 bresp;
  logic                      bvalid;
  logic                      bready;
  logic [`CORE_ADDR_W-1:0]   araddr;
  logic                      arvalid;
  logic                      arready;
  logic [`CORE_DATA_W-1:0]   rdata;
  axi_resp_t                 rresp;
  logic                      rvalid;
  logic                      rready;
  logic                      halted;
  logic                      bus_error;
  logic [`CORE_OFF_W-1:0]    ip;

  logic [`CORE_DATA_W-1:0]   mem [0:511];
  logic [`CORE_ADDR_W-1:0]   rd_addr;
  logic [`CORE_ADDR_W-1:0]   err_addr;
  logic [31:0]               alu_a;
  logic [31:0]               alu_b;
  logic                      err_en;
  logic                      heavy;
  logic                      rd_hs;
  logic                      wr_hs;
  integer                    seed;
  int                        d_aw;
  int                        d_w;
  int                        cyc;
  int                        cycles = 0;
  int                        limit = 200;
  int                        n_tests = 0;

  internal_bus internal_bus_i (.*);

  tb_checker chk_i (
    .clk(clk), .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
    .wstrb(wstrb), .wvalid(wvalid), .wready(wready), .halted(halted),
    .bus_error(bus_error), .ip(ip)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("run timed out after %0d cycles without the program halting", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // delays of 0 to 1 cycles in light mode and 0 to 7 in heavy mode
  function automatic int pick_delay();
    return int'($unsigned($random(seed)) % (heavy ? 32'd8 : 32'd2));
  endfunction

  function automatic logic faults(input logic [31:0] addr);
    return err_en && (addr == err_addr);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // read side of the memory model
  always begin
    @(negedge clk);
    if (!rst && arvalid) begin
      wait_cycles(pick_delay());
      arready = 1'b1;
      rd_addr = araddr;
      @(negedge clk);
      arready = 1'b0;
      wait_cycles(pick_delay());
      rdata = mem[rd_addr[10:2]];
      rresp = faults(rd_addr) ? RESP_SLVERR : RESP_OKAY;
      rvalid = 1'b1;
      rd_hs = rready;
      @(negedge clk);
      while (!rd_hs) begin
        rd_hs = rready;
        @(negedge clk);
      end
      rvalid = 1'b0;
    end
  end

  // write side with separate aw and w ready delays
  always begin
    @(negedge clk);
    if (!rst && awvalid) begin
      d_aw = pick_delay();
      d_w = pick_delay();
      for (cyc = 0; cyc <= d_aw || cyc <= d_w; cyc++) begin
        awready = (cyc == d_aw);
        wready = (cyc == d_w);
        @(negedge clk);
      end
      awready = 1'b0;
      wready = 1'b0;
      wait_cycles(pick_delay());
      bresp = faults(awaddr) ? RESP_SLVERR : RESP_OKAY;
      if (!faults(awaddr)) begin
        mem[awaddr[10:2]] = wdata;
      end
      bvalid = 1'b1;
      wr_hs = bready;
      @(negedge clk);
      while (!wr_hs) begin
        wr_hs = bready;
        @(negedge clk);
      end
      bvalid = 1'b0;
    end
  end

  task automatic set_word(input logic [8:0] idx, input logic [31:0] val);
    mem[idx] = val;
    chk_i.load_word(idx, val);
  endtask

  task automatic set_cmd(input logic [7:0] at, input logic [3:0] op, input logic [1:0] cnd,
                         input logic [7:0] s1, input logic [7:0] s0, input logic [7:0] dst);
    set_word({1'b0, at}, {op, 2'b00, cnd, s1, s0, dst});
  endtask

  task automatic set_data(input logic [7:0] off, input logic [31:0] val);
    set_word({1'b1, off}, val);
  endtask

  task automatic clear_mem();
    for (int i = 0; i < 512; i++) begin
      set_word(9'(i), (32'(i) * 32'h2545_f491) ^ 32'h5a5a_5a5a);
    end
  endtask

  // every alu opcode on the same pair of operands
  task automatic build_alu();
    clear_mem();
    set_data(8'd0, alu_a);
    set_data(8'd1, alu_b);
    for (int k = 0; k < 8; k++) begin
      set_cmd(8'(k), 4'(k), CND_ALWAYS, 8'd0, 8'd1, 8'(10 + k));
    end
    set_cmd(8'd8, OP_HALT, CND_ALWAYS, 8'd0, 8'd0, 8'd0);
  endtask

  // each condition against zero, positive and negative src1
  task automatic build_cond();
    clear_mem();
    set_data(8'd0, 32'd0);
    set_data(8'd1, 32'd5);
    set_data(8'd2, 32'h8000_0000 | alu_b);
    set_data(8'd3, alu_a);
    for (int c = 0; c < 4; c++) begin
      for (int v = 0; v < 3; v++) begin
        set_cmd(8'(c * 3 + v), OP_MOV, 2'(c), 8'(v), 8'd3, 8'(20 + c * 3 + v));
      end
    end
    // unused opcode stops the core too
    set_cmd(8'd12, 4'hf, CND_ALWAYS, 8'd0, 8'd0, 8'd0);
  endtask

  // one setup move and then five passes of count down and accumulate
  // loop body starts at command 1 so the jump target is not zero
  task automatic build_loop();
    clear_mem();
    set_data(8'd0, 32'd5);
    set_data(8'd1, 32'd1);
    set_data(8'd2, 32'd0);
    set_data(8'd3, 32'd7);
    set_cmd(8'd0, OP_MOV, CND_ALWAYS, 8'd3, 8'd0, 8'd4);
    set_cmd(8'd1, OP_SUB, CND_ALWAYS, 8'd0, 8'd1, 8'd0);
    set_cmd(8'd2, OP_ADD, CND_ALWAYS, 8'd2, 8'd4, 8'd2);
    set_cmd(8'd3, OP_JMP, CND_NONZERO, 8'd0, 8'd3, 8'd1);
    set_cmd(8'd4, OP_HALT, CND_ALWAYS, 8'd0, 8'd0, 8'd0);
  endtask

  task automatic run_test(input logic fault_en, input logic [31:0] fault_addr);
    int cmds;
    err_en = fault_en;
    err_addr = fault_addr;
    n_tests++;
    chk_i.begin_test(n_tests, base_addr, base_addr_data, fault_en, fault_addr, cmds);
    limit = limit + 64 * cmds;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    @(negedge clk);
    while (!halted) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    base_addr = PROG_BASE;
    base_addr_data = DATA_BASE;
    awready = 1'b0;
    wready = 1'b0;
    bresp = RESP_OKAY;
    bvalid = 1'b0;
    arready = 1'b0;
    rdata = '0;
    rresp = RESP_OKAY;
    rvalid = 1'b0;
    err_en = 1'b0;
    err_addr = '0;
    heavy = 1'b0;
    seed = 32'hd4620911;
    alu_a = $random(seed);
    alu_b = $random(seed);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    build_alu();
    run_test(1'b0, 32'd0);
    build_cond();
    run_test(1'b0, 32'd0);
    build_loop();
    run_test(1'b0, 32'd0);
    heavy = 1'b1;
    build_alu();
    run_test(1'b0, 32'd0);
    build_cond();
    run_test(1'b0, 32'd0);
    build_loop();
    run_test(1'b0, 32'd0);
    heavy = 1'b0;
    // slverr on the jmp fetch and then on the and destination
    build_loop();
    run_test(1'b1, PROG_BASE + 32'd12);
    build_alu();
    run_test(1'b1, DATA_BASE + 32'd48);
    // restart straight out of the error halt
    build_cond();
    run_test(1'b0, 32'd0);
    $display("tests run %0d, passed %0d, failed %0d",
             n_tests, chk_i.pass_count, chk_i.fail_count);
    if (chk_i.fail_count == 0 && chk_i.pass_count == n_tests) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
